// ==== alu_config.svh ====
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath width of the execute unit
`define ALU_XLEN 64

// width of the ALU operation code
`define ALU_OP_W 5

// shift-subtract steps of the radix-2 divider, one per quotient bit
`define ALU_DIV_STEPS 64

// low half used by W operations
`define ALU_HALF (`ALU_XLEN / 2)

`endif

// ==== alu_pkg.sv ====
`default_nettype none

package aluPkg;

`include "alu_config.svh"

    // operand and result words
    typedef logic [`ALU_XLEN-1:0] word_t;

    // low half for W forms
    typedef logic [`ALU_HALF-1:0] half_t;

    typedef logic [`ALU_OP_W-1:0] aluOp_t;

    // multiply variant
    // 0 low product, 1 high uu, 2 high su, 3 high ss
    typedef logic [1:0] mulOp_t;

    // shift amount, up to 63
    typedef logic [5:0] shamt_t;

    // result source select
    typedef enum logic [3:0] {
        SEL_ADD   = 4'd0,
        SEL_AND   = 4'd1,
        SEL_OR    = 4'd2,
        SEL_XOR   = 4'd3,
        SEL_SHIFT = 4'd4,
        SEL_PASSB = 4'd5,
        SEL_CMP   = 4'd6,
        SEL_MUL   = 4'd7,
        SEL_DIV   = 4'd8,
        SEL_REM   = 4'd9
    } opSel_t;

    // decoded control bundle
    typedef struct packed {
        logic   sub;
        logic   signedOp;
        logic   arith;
        logic   shiftRight;
        logic   word;
        opSel_t sel;
    } aluCtrl_t;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } divState_t;

endpackage

`default_nettype wire

// ==== alu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecode import aluPkg::*; (
    input  aluOp_t   op,
    output aluCtrl_t ctrl
);

    always_comb begin
        // unknown codes fall through as a plain add
        ctrl = '{sub: 1'b0, signedOp: 1'b0, arith: 1'b0, shiftRight: 1'b0,
                 word: op[4], sel: SEL_ADD};
        case (op)
            5'b00000, 5'b10000: begin
                ctrl.sel = SEL_ADD;
            end
            5'b01000, 5'b11000: begin
                ctrl.sub = 1'b1;
                ctrl.sel = SEL_ADD;
            end
            5'b00001, 5'b10001: begin
                ctrl.sel = SEL_SHIFT;
            end
            5'b00101, 5'b10101: begin
                ctrl.shiftRight = 1'b1;
                ctrl.sel        = SEL_SHIFT;
            end
            5'b01101, 5'b11101: begin
                ctrl.shiftRight = 1'b1;
                ctrl.arith      = 1'b1;
                ctrl.sel        = SEL_SHIFT;
            end
            // compares run through the adder as a subtract
            5'b00010: begin
                ctrl.sub      = 1'b1;
                ctrl.signedOp = 1'b1;
                ctrl.sel      = SEL_CMP;
            end
            5'b00011: begin
                ctrl.sub = 1'b1;
                ctrl.sel = SEL_CMP;
            end
            5'b00100: ctrl.sel = SEL_XOR;
            5'b00110: ctrl.sel = SEL_OR;
            5'b00111: ctrl.sel = SEL_AND;
            5'b01111: ctrl.sel = SEL_PASSB;
            5'b01001, 5'b11001: begin
                ctrl.sel = SEL_MUL;
            end
            // divide and remainder, unsigned then signed
            5'b01010, 5'b11010: begin
                ctrl.sel = SEL_DIV;
            end
            5'b01011, 5'b11011: begin
                ctrl.signedOp = 1'b1;
                ctrl.sel      = SEL_DIV;
            end
            5'b01100, 5'b11100: begin
                ctrl.sel = SEL_REM;
            end
            5'b01110, 5'b11110: begin
                ctrl.signedOp = 1'b1;
                ctrl.sel      = SEL_REM;
            end
            default: begin
                ctrl.word = 1'b0;
                ctrl.sel  = SEL_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module aluExecute import aluPkg::*; (
    input  word_t    a,
    input  word_t    b,
    input  aluCtrl_t ctrl,
    input  mulOp_t   mulOp,
    output word_t    execRes,
    output logic     zero,
    output word_t    dividend,
    output word_t    divisor
);

    logic  [`ALU_XLEN:0] sumFull;
    word_t bIn;
    word_t sum;
    logic  carry;
    logic  sign;
    logic  overflow;
    word_t addRes;
    word_t cmpRes;

    half_t  aLo;
    shamt_t shamt;
    word_t  shift64;
    half_t  shift32;
    word_t  shiftRes;

    logic  signA;
    logic  signB;
    logic  [2*`ALU_XLEN-1:0] mulA;
    logic  [2*`ALU_XLEN-1:0] mulB;
    logic  [2*`ALU_XLEN-1:0] product;
    word_t mulRes;

    // adder, subtract by inverting b and feeding a carry in
    assign bIn     = b ^ {`ALU_XLEN{ctrl.sub}};
    assign sumFull = {1'b0, a} + {1'b0, bIn} + {{`ALU_XLEN{1'b0}}, ctrl.sub};
    assign sum     = sumFull[`ALU_XLEN-1:0];
    assign carry   = sumFull[`ALU_XLEN];
    assign sign    = sum[`ALU_XLEN-1];
    assign overflow = (a[`ALU_XLEN-1] == bIn[`ALU_XLEN-1]) &&
                      (sign != a[`ALU_XLEN-1]);
    assign zero    = (sum == '0);

    assign addRes = ctrl.word ? {{`ALU_HALF{sum[`ALU_HALF-1]}}, sum[`ALU_HALF-1:0]} : sum;

    // unsigned less-than is the borrow, i.e. no carry out of a - b
    assign cmpRes = {{(`ALU_XLEN-1){1'b0}}, ctrl.signedOp ? (overflow ^ sign) : ~carry};

    // shifter
    assign aLo   = a[`ALU_HALF-1:0];
    assign shamt = b[5:0];

    always_comb begin
        if (!ctrl.shiftRight) begin
            shift64 = a << shamt;
            shift32 = aLo << shamt[4:0];
        end else if (ctrl.arith) begin
            shift64 = $signed(a) >>> shamt;
            shift32 = $signed(aLo) >>> shamt[4:0];
        end else begin
            shift64 = a >> shamt;
            shift32 = aLo >> shamt[4:0];
        end
    end

    assign shiftRes = ctrl.word ? {{`ALU_HALF{shift32[`ALU_HALF-1]}}, shift32} : shift64;

    // one 128-bit multiplier, extension picked per variant
    assign signA   = mulOp[1];
    assign signB   = (mulOp == 2'd3);
    assign mulA    = {{`ALU_XLEN{signA & a[`ALU_XLEN-1]}}, a};
    assign mulB    = {{`ALU_XLEN{signB & b[`ALU_XLEN-1]}}, b};
    assign product = mulA * mulB;

    always_comb begin
        if (mulOp != 2'd0) begin
            mulRes = product[2*`ALU_XLEN-1:`ALU_XLEN];
        end else if (ctrl.word) begin
            // low 32 bits do not depend on the extension
            mulRes = {{`ALU_HALF{product[`ALU_HALF-1]}}, product[`ALU_HALF-1:0]};
        end else begin
            mulRes = product[`ALU_XLEN-1:0];
        end
    end

    always_comb begin
        case (ctrl.sel)
            SEL_AND:   execRes = a & b;
            SEL_OR:    execRes = a | b;
            SEL_XOR:   execRes = a ^ b;
            SEL_SHIFT: execRes = shiftRes;
            SEL_PASSB: execRes = b;
            SEL_CMP:   execRes = cmpRes;
            SEL_MUL:   execRes = mulRes;
            default:   execRes = addRes;
        endcase
    end

    // divider operands, W forms extended by signedness
    assign dividend = ctrl.word ?
        {{`ALU_HALF{ctrl.signedOp & a[`ALU_HALF-1]}}, a[`ALU_HALF-1:0]} : a;
    assign divisor  = ctrl.word ?
        {{`ALU_HALF{ctrl.signedOp & b[`ALU_HALF-1]}}, b[`ALU_HALF-1:0]} : b;

endmodule

`default_nettype wire

// ==== alu_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module aluDivider import aluPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  signedOp,
    input  logic  word,
    input  word_t dividend,
    input  word_t divisor,
    output logic  ready,
    output logic  outValid,
    output word_t quotient,
    output word_t remainder
);

    divState_t state;
    logic [$clog2(`ALU_DIV_STEPS)-1:0] stepCnt;

    word_t quoR;
    word_t remR;
    word_t divMag;
    word_t savedDividend;
    logic  negQ;
    logic  negR;
    logic  wordR;
    logic  divZero;
    logic  ovf;

    word_t absDividend;
    word_t absDivisor;
    logic  [`ALU_XLEN:0] shifted;
    logic  [`ALU_XLEN:0] diff;
    word_t qFix;
    word_t rFix;

    assign ready    = (state == DIV_IDLE);
    assign outValid = (state == DIV_DONE);

    assign absDividend = (signedOp && dividend[`ALU_XLEN-1]) ? -dividend : dividend;
    assign absDivisor  = (signedOp && divisor[`ALU_XLEN-1]) ? -divisor : divisor;

    // one restoring step
    assign shifted = {remR, quoR[`ALU_XLEN-1]};
    assign diff    = shifted - {1'b0, divMag};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= DIV_IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state   <= DIV_RUN;
                        stepCnt <= '0;
                    end
                end
                DIV_RUN: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == ($clog2(`ALU_DIV_STEPS))'(`ALU_DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            quoR          <= absDividend;
            remR          <= '0;
            divMag        <= absDivisor;
            savedDividend <= dividend;
            negQ          <= signedOp & (dividend[`ALU_XLEN-1] ^ divisor[`ALU_XLEN-1]);
            negR          <= signedOp & dividend[`ALU_XLEN-1];
            wordR         <= word;
            divZero       <= (divisor == '0);
            // most negative / -1, only the 64-bit case needs a fix-up
            ovf           <= signedOp && !word && (divisor == '1) &&
                             (dividend == {1'b1, {(`ALU_XLEN-1){1'b0}}});
        end else if (state == DIV_RUN) begin
            if (!diff[`ALU_XLEN]) begin
                remR <= diff[`ALU_XLEN-1:0];
                quoR <= {quoR[`ALU_XLEN-2:0], 1'b1};
            end else begin
                remR <= shifted[`ALU_XLEN-1:0];
                quoR <= {quoR[`ALU_XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix-up and RISC-V corner cases
    always_comb begin
        qFix = negQ ? -quoR : quoR;
        rFix = negR ? -remR : remR;
        if (divZero) begin
            qFix = '1;
            rFix = savedDividend;
        end else if (ovf) begin
            qFix = savedDividend;
            rFix = '0;
        end
    end

    assign quotient  = wordR ?
        {{`ALU_HALF{qFix[`ALU_HALF-1]}}, qFix[`ALU_HALF-1:0]} : qFix;
    assign remainder = wordR ?
        {{`ALU_HALF{rFix[`ALU_HALF-1]}}, rFix[`ALU_HALF-1:0]} : rFix;

endmodule

`default_nettype wire

// ==== alu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluResult import aluPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  aluCtrl_t ctrl,
    input  word_t    execRes,
    input  logic     mwbBlock,
    input  logic     divReady,
    input  logic     outValid,
    input  word_t    quotient,
    input  word_t    remainder,
    output logic     divStart,
    output logic     aluBusy,
    output word_t    result
);

    logic  isDiv;
    logic  running;
    logic  doneHeld;
    word_t quoHeld;
    word_t remHeld;
    word_t divRes;

    assign isDiv = (ctrl.sel == SEL_DIV) || (ctrl.sel == SEL_REM);

    // start only from a clean state, never while a result is parked
    assign divStart = isDiv && !running && !outValid && !doneHeld;
    assign aluBusy  = isDiv && !outValid && !doneHeld;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (outValid) begin
            running <= 1'b0;
        end else if (divStart && divReady) begin
            running <= 1'b1;
        end
    end

    // finished result stalled downstream
    always_ff @(posedge clk) begin
        if (rst || !mwbBlock) begin
            doneHeld <= 1'b0;
        end else if (outValid) begin
            doneHeld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (outValid) begin
            quoHeld <= quotient;
            remHeld <= remainder;
        end
    end

    // live output in the done cycle, captured copy afterwards
    always_comb begin
        if (outValid) begin
            divRes = (ctrl.sel == SEL_REM) ? remainder : quotient;
        end else begin
            divRes = (ctrl.sel == SEL_REM) ? remHeld : quoHeld;
        end
    end

    assign result = isDiv ? divRes : execRes;

endmodule

`default_nettype wire

// ==== alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTop import aluPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    input  mulOp_t mulOp,
    input  logic   mwbBlock,
    output logic   aluBusy,
    output logic   zero,
    output word_t  result
);

    aluCtrl_t ctrl;
    word_t    execRes;
    word_t    dividend;
    word_t    divisor;
    word_t    quotient;
    word_t    remainder;
    logic     divStart;
    logic     divReady;
    logic     outValid;

    aluDecode i_aluDecode (
        .op   (op),
        .ctrl (ctrl)
    );

    aluExecute i_aluExecute (
        .a        (a),
        .b        (b),
        .ctrl     (ctrl),
        .mulOp    (mulOp),
        .execRes  (execRes),
        .zero     (zero),
        .dividend (dividend),
        .divisor  (divisor)
    );

    aluDivider i_aluDivider (
        .clk       (clk),
        .rst       (rst),
        .start     (divStart),
        .signedOp  (ctrl.signedOp),
        .word      (ctrl.word),
        .dividend  (dividend),
        .divisor   (divisor),
        .ready     (divReady),
        .outValid  (outValid),
        .quotient  (quotient),
        .remainder (remainder)
    );

    aluResult i_aluResult (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .execRes   (execRes),
        .mwbBlock  (mwbBlock),
        .divReady  (divReady),
        .outValid  (outValid),
        .quotient  (quotient),
        .remainder (remainder),
        .divStart  (divStart),
        .aluBusy   (aluBusy),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== tb_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_config.svh"

module tbAlu import aluPkg::*; ();

    localparam int NUM_RANDOM     = 300;
    localparam int NUM_DIV_RANDOM = 40;
    // shifts 24, mul 32, directed div 24, held 3, reset check 1
    localparam int NUM_TXN = NUM_RANDOM + NUM_DIV_RANDOM + 24 + 32 + 24 + 3 + 1;
    localparam int TIMEOUT_CYCLES = NUM_TXN * (`ALU_DIV_STEPS + 8) + 100;

    localparam word_t MIN64 = {1'b1, {(`ALU_XLEN-1){1'b0}}};
    localparam word_t MIN32 = 64'hFFFF_FFFF_8000_0000;

    logic   clk = 1'b0;
    logic   rst;
    word_t  a;
    word_t  b;
    aluOp_t op;
    mulOp_t mulOp;
    logic   mwbBlock;
    logic   aluBusy;
    logic   zero;
    word_t  result;

    integer seed = 32'h41bf_e18b;
    int     cycleCount = 0;
    int     wordErrors = 0;
    int     flagErrors = 0;
    int     protocolErrors = 0;

    aluOp_t singleOps [18] = '{5'b00000, 5'b10000, 5'b00001, 5'b10001, 5'b00010, 5'b00011,
                               5'b00100, 5'b00101, 5'b10101, 5'b00110, 5'b00111, 5'b01000,
                               5'b11000, 5'b01101, 5'b11101, 5'b01111, 5'b01001, 5'b11001};
    aluOp_t divOps [8] = '{5'b01010, 5'b01011, 5'b01100, 5'b01110,
                           5'b11010, 5'b11011, 5'b11100, 5'b11110};
    aluOp_t shiftOps [6] = '{5'b00001, 5'b10001, 5'b00101, 5'b10101, 5'b01101, 5'b11101};
    shamt_t shiftAmounts [4] = '{6'd0, 6'd31, 6'd32, 6'd63};

    aluTop i_aluTop (
        .clk      (clk),
        .rst      (rst),
        .a        (a),
        .b        (b),
        .op       (op),
        .mulOp    (mulOp),
        .mwbBlock (mwbBlock),
        .aluBusy  (aluBusy),
        .zero     (zero),
        .result   (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic word_t signExtend(half_t v);
        return {{`ALU_HALF{v[`ALU_HALF-1]}}, v};
    endfunction

    // random word, biased towards corner values
    function automatic word_t pickOperand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return MIN64;
            3'd3:    return {60'd0, r[7:4]};
            3'd4:    return MIN32;
            3'd5:    return {32'd0, $random(seed)};
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    function automatic word_t modelDivide(aluOp_t o, word_t x, word_t y);
        logic        isRem;
        logic        isSigned;
        word_t       q;
        word_t       rm;
        logic [31:0] ux;
        logic [31:0] uy;
        logic signed [31:0] sx;
        logic signed [31:0] sy;
        isRem    = (o[3:0] == 4'b1100) || (o[3:0] == 4'b1110);
        isSigned = (o[3:0] == 4'b1011) || (o[3:0] == 4'b1110);
        ux = x[31:0];
        uy = y[31:0];
        sx = x[31:0];
        sy = y[31:0];
        if (!o[4]) begin
            if (y == '0) begin
                q  = '1;
                rm = x;
            end else if (isSigned && x == MIN64 && y == '1) begin
                q  = x;
                rm = '0;
            end else if (isSigned) begin
                q  = $signed(x) / $signed(y);
                rm = $signed(x) % $signed(y);
            end else begin
                q  = x / y;
                rm = x % y;
            end
        end else begin
            // W forms work on the low halves
            if (uy == 32'd0) begin
                q  = '1;
                rm = signExtend(ux);
            end else if (isSigned && ux == 32'h8000_0000 && uy == 32'hFFFF_FFFF) begin
                q  = signExtend(ux);
                rm = '0;
            end else if (isSigned) begin
                q  = signExtend(sx / sy);
                rm = signExtend(sx % sy);
            end else begin
                q  = signExtend(ux / uy);
                rm = signExtend(ux % uy);
            end
        end
        return isRem ? rm : q;
    endfunction

    function automatic word_t modelResult(aluOp_t o, word_t x, word_t y, mulOp_t m);
        half_t xl;
        half_t yl;
        logic signed [127:0] sx;
        logic signed [127:0] sy;
        logic [127:0] ux;
        logic [127:0] uy;
        logic [127:0] prod;
        xl = x[31:0];
        yl = y[31:0];
        sx = $signed(x);
        sy = $signed(y);
        ux = x;
        uy = y;
        case (m)
            2'd2:    prod = sx * uy;
            2'd3:    prod = sx * sy;
            default: prod = ux * uy;
        endcase
        case (o)
            5'b10000: return signExtend(xl + yl);
            5'b01000: return x - y;
            5'b11000: return signExtend(xl - yl);
            5'b00001: return x << y[5:0];
            5'b10001: return signExtend(xl << y[4:0]);
            5'b00101: return x >> y[5:0];
            5'b10101: return signExtend(xl >> y[4:0]);
            5'b01101: return $signed(x) >>> y[5:0];
            5'b11101: return signExtend($signed(xl) >>> y[4:0]);
            5'b00010: return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
            5'b00011: return (x < y) ? 64'd1 : 64'd0;
            5'b00100: return x ^ y;
            5'b00110: return x | y;
            5'b00111: return x & y;
            5'b01111: return y;
            5'b01001: return (m == 2'd0) ? prod[63:0] : prod[127:64];
            5'b11001: return (m == 2'd0) ? signExtend(prod[31:0]) : prod[127:64];
            5'b01010, 5'b01011, 5'b01100, 5'b01110,
            5'b11010, 5'b11011, 5'b11100, 5'b11110: return modelDivide(o, x, y);
            default:  return x + y;
        endcase
    endfunction

    // sub and the compares go through the adder as a - b
    function automatic logic modelZero(aluOp_t o, word_t x, word_t y);
        if (o == 5'b01000 || o == 5'b11000 || o == 5'b00010 || o == 5'b00011) begin
            return (x - y) == '0;
        end
        return (x + y) == '0;
    endfunction

    task automatic checkWord(word_t got, word_t exp, string what);
        if (got !== exp) begin
            wordErrors++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(logic got, logic exp, string what);
        if (got !== exp) begin
            flagErrors++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic runSingle(aluOp_t o, word_t x, word_t y, mulOp_t m);
        string what;
        what = $sformatf("op %b a %h b %h mulOp %0d", o, x, y, m);
        @(posedge clk);
        op    <= o;
        a     <= x;
        b     <= y;
        mulOp <= m;
        @(negedge clk);
        checkWord(result, modelResult(o, x, y, m), what);
        checkFlag(zero, modelZero(o, x, y), {what, " zero"});
        checkFlag(aluBusy, 1'b0, {what, " aluBusy"});
    endtask

    task automatic runDivide(aluOp_t o, word_t x, word_t y, logic hold, int holdCycles);
        word_t exp;
        int    waited;
        string what;
        exp  = modelResult(o, x, y, 2'd0);
        what = $sformatf("div op %b a %h b %h", o, x, y);
        @(posedge clk);
        op       <= o;
        a        <= x;
        b        <= y;
        mulOp    <= 2'd0;
        mwbBlock <= hold;
        @(negedge clk);
        checkFlag(aluBusy, 1'b1, {what, " aluBusy when presented"});
        waited = 0;
        while (aluBusy === 1'b1 && waited < `ALU_DIV_STEPS + 2) begin
            @(negedge clk);
            waited++;
        end
        if (aluBusy !== 1'b0) begin
            protocolErrors++;
            $display("%s: aluBusy still high %0d cycles after the division started",
                     what, waited);
        end else begin
            checkWord(result, exp, what);
            if (hold) begin
                // finished result parked while write-back stalls
                for (int i = 0; i < holdCycles; i++) begin
                    @(negedge clk);
                    checkFlag(aluBusy, 1'b0, {what, " aluBusy while held"});
                    checkWord(result, exp, {what, " held"});
                end
                @(posedge clk);
                mwbBlock <= 1'b0;
                @(negedge clk);
                checkFlag(aluBusy, 1'b0, {what, " aluBusy on release"});
                checkWord(result, exp, {what, " on release"});
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        word_t       x;
        word_t       y;
        rst      = 1'b1;
        a        = '0;
        b        = '0;
        op       = 5'b00000;
        mulOp    = 2'd0;
        mwbBlock = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkFlag(aluBusy, 1'b0, "aluBusy after reset");

        // shift amounts at the edges of both widths
        foreach (shiftOps[i]) begin
            foreach (shiftAmounts[k]) begin
                x = pickOperand();
                y = {pickOperand() >> 6, shiftAmounts[k]};
                runSingle(shiftOps[i], x, y, 2'd0);
            end
        end

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                x = pickOperand();
                y = pickOperand();
                runSingle(5'b01001, x, y, mulOp_t'(k));
                runSingle(5'b11001, x, y, mulOp_t'(k));
            end
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            x = pickOperand();
            y = pickOperand();
            runSingle(singleOps[r[15:8] % 18], x, y, r[1:0]);
        end

        // divide by zero and overflow for every division form
        foreach (divOps[i]) begin
            runDivide(divOps[i], pickOperand(), '0, 1'b0, 0);
            runDivide(divOps[i], MIN64, '1, 1'b0, 0);
            runDivide(divOps[i], MIN32, '1, 1'b0, 0);
        end

        for (int i = 0; i < NUM_DIV_RANDOM; i++) begin
            r = $random(seed);
            x = pickOperand();
            y = pickOperand();
            runDivide(divOps[r[2:0]], x, y, 1'b0, 0);
        end

        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            x = pickOperand();
            y = pickOperand();
            runDivide(divOps[r[2:0]], x, y, 1'b1, 3 + i);
        end
        runSingle(5'b00000, pickOperand(), pickOperand(), 2'd0);

        $display("checks done: %0d result errors, %0d flag errors, %0d protocol errors",
                 wordErrors, flagErrors, protocolErrors);
        if (wordErrors + flagErrors + protocolErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
alu_pkg.sv
alu_decode.sv
alu_execute.sv
alu_divider.sv
alu_result.sv
alu_top.sv
tb_alu.sv
